// File: audio_effects_top.f
audio_pkg.sv
adc_serial_rx.sv
lowpass_stage.sv
pushbutton_toggle.sv
dac_sigma_delta.sv
audio_effects_top.sv
tb_audio_effects.sv

// File: run_sim.sh
#!/bin/sh
# Builds the audio path testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

verilator --binary --timing \
    --top-module tb_audio_effects \
    --Mdir obj_dir \
    -f audio_effects_top.f

# Simulation output goes to the console and is searched for the pass line
out=$(./obj_dir/Vtb_audio_effects 2>&1) || true
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx "Regression passed"; then
    exit 0
fi

echo "Simulation did not report a pass"
exit 1

// File: tb_audio_effects.sv
/*
 * Testbench for the audio path top level. Models the serial ADC, presses
 * the stage buttons, and compares the dac_out ones density of every frame
 * with a reference filter cascade. Rows of a stimulus table run in a loop.
 */
`timescale 1ns/1ps

module tb_audio_effects;
    import audio_pkg::*;

    localparam int CLK_PERIOD   = 20;
    localparam int DRIVE_DELAY  = 2;
    localparam int FRAME_CYCLES = BIT_CYCLES * FRAME_BITS;
    localparam int FULL_SCALE   = 1 << SAMPLE_W;
    localparam int HALF_SCALE   = 1 << (SAMPLE_W - 1);
    localparam int VOL_MAX      = (1 << VOL_W) - 1;

    // DAC level is steady over frame cycles 6 to 69 where ones are counted
    localparam int WIN_START = 6;
    localparam int WIN       = 64;

    // Button press starts one cycle into the frame
    localparam int PRESS_START = 1;
    localparam int LONG_PRESS  = 16;
    localparam int SHORT_PRESS = 4;

    // Row modes
    localparam int MODE_FIXED = 0;
    localparam int MODE_SHORT = 1;
    localparam int MODE_RAND  = 2;

    // Stimulus table with one entry per row in each array
    // Columns are sample, volume, buttons pressed in the first frame, mode and frame count
    localparam int NUM_ROWS = 15;
    localparam logic [SAMPLE_W-1:0] ROW_SAMPLE [NUM_ROWS] = '{
        16'h8000, 16'h0000, 16'h4000, 16'h7fff, 16'h8000,
        16'h7000, 16'h7000, 16'hc000, 16'hc000, 16'h2000,
        16'hb000, 16'hb000, 16'hb000, 16'hb000, 16'h0000
    };
    localparam logic [VOL_W-1:0] ROW_VOL [NUM_ROWS] = '{
        2'd3, 2'd3, 2'd3, 2'd3, 2'd3,
        2'd3, 2'd3, 2'd3, 2'd3, 2'd3,
        2'd0, 2'd1, 2'd2, 2'd3, 2'd0
    };
    localparam logic [NUM_STAGES-1:0] ROW_MASK [NUM_ROWS] = '{
        4'h0, 4'h0, 4'h0, 4'h0, 4'h0,
        4'hf, 4'h1, 4'h2, 4'h1, 4'hf,
        4'h0, 4'h0, 4'h0, 4'h0, 4'h0
    };
    localparam int ROW_MODE [NUM_ROWS] = '{
        MODE_FIXED, MODE_FIXED, MODE_FIXED, MODE_FIXED, MODE_FIXED,
        MODE_FIXED, MODE_FIXED, MODE_SHORT, MODE_FIXED, MODE_FIXED,
        MODE_FIXED, MODE_FIXED, MODE_FIXED, MODE_FIXED, MODE_RAND
    };
    localparam int ROW_FRAMES [NUM_ROWS] = '{
        3, 3, 3, 3, 2,
        8, 2, 2, 2, 2,
        2, 2, 2, 2, 20
    };

    logic                  clk;
    logic                  rst_n;
    logic                  adc_serial_in;
    logic [NUM_STAGES-1:0] pbs;
    logic [VOL_W-1:0]      vol;
    logic                  ws_adc;
    logic                  i2sclk;
    logic                  dac_out;

    // Reference model state
    int                    model_state [NUM_STAGES];
    logic [NUM_STAGES-1:0] model_en;
    // Offset level expected at the DAC during the current frame
    int                    prev_offset;
    int                    seed;
    int                    cycle_cnt;

    audio_effects_top dut0 (
        .clk           (clk),
        .rst_n         (rst_n),
        .adc_serial_in (adc_serial_in),
        .pbs           (pbs),
        .vol           (vol),
        .ws_adc        (ws_adc),
        .i2sclk        (i2sclk),
        .dac_out       (dac_out)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic int total_frames();
        int sum;
        sum = 0;
        for (int r = 0; r < NUM_ROWS; r++) begin
            sum += ROW_FRAMES[r];
        end
        return sum;
    endfunction

    // Run limit from the table length plus the closing frame and slack
    initial begin
        int limit;
        limit = (total_frames() + 1) * FRAME_CYCLES + 2000;
        cycle_cnt = 0;
        while (cycle_cnt < limit) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("Timeout: run did not finish within %0d clock cycles", limit);
        $display("Regression failed");
        $fatal(1, "timeout");
    end

    task automatic check_value(input string what, input int got, input int exp);
        if (got != exp) begin
            $display("error at %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
            $display("Regression failed");
            $fatal(1, "value mismatch");
        end
    endtask

    // Wait for the next rising edge and settle before sampling and driving
    task automatic step_cycle();
        @(posedge clk);
        #DRIVE_DELAY;
    endtask

    // First-order carry count over the window is floor or floor plus one
    task automatic check_density(input int ones, input int offset);
        int scaled;
        int exp_ones;
        scaled   = WIN * offset;
        exp_ones = scaled / FULL_SCALE;
        // Start value of the accumulator can add one carry
        if (ones == exp_ones + 1 && (scaled % FULL_SCALE) != 0) begin
            exp_ones = exp_ones + 1;
        end
        check_value("dac_out ones in window", ones, exp_ones);
    endtask

    // Each of the four stages takes a quarter step toward its input or copies it
    task automatic step_model(input logic [SAMPLE_W-1:0] word, input logic [VOL_W-1:0] v,
                              input logic [NUM_STAGES-1:0] toggles, output int offset);
        int x;
        model_en = model_en ^ toggles;
        x = int'($signed(word));
        for (int k = 0; k < NUM_STAGES; k++) begin
            if (model_en[k]) begin
                model_state[k] = model_state[k] + ((x - model_state[k]) >>> LPF_SHIFT);
            end else begin
                model_state[k] = x;
            end
            x = model_state[k];
        end
        offset = (x >>> (VOL_MAX - int'(v))) + HALF_SCALE;
    endtask

    // Enters at cycle 0 of a frame and leaves at cycle 0 of the next one
    task automatic run_frame(input logic [SAMPLE_W-1:0] word, input logic [VOL_W-1:0] v,
                             input logic [NUM_STAGES-1:0] mask, input int press_len);
        int ones;
        int bit_idx;
        int new_offset;
        logic last_sclk;
        ones      = 0;
        bit_idx   = 0;
        last_sclk = i2sclk;
        vol       = v;
        // Presses under the debounce length do not count
        step_model(word, v, (press_len >= DEBOUNCE_CYCLES) ? mask : '0, new_offset);
        for (int c = 0; c < FRAME_CYCLES; c++) begin
            if (c > 0) begin
                step_cycle();
            end
            // Word select high for one bit period per frame and bit clock 2 high 2 low
            check_value("ws_adc", int'(ws_adc), int'(c < BIT_CYCLES));
            check_value("i2sclk", int'(i2sclk), int'((c % BIT_CYCLES) < BIT_CYCLES / 2));
            // ADC model drives the next bit MSB first on the bit clock fall
            if (last_sclk && !i2sclk && bit_idx < SAMPLE_W) begin
                adc_serial_in = word[SAMPLE_W - 1 - bit_idx];
                bit_idx++;
            end
            last_sclk = i2sclk;
            if (c == PRESS_START) begin
                pbs = mask;
            end
            if (c == PRESS_START + press_len) begin
                pbs = '0;
            end
            if (c >= WIN_START && c < WIN_START + WIN) begin
                ones += int'(dac_out);
            end
        end
        // Window belonged to the level latched in the previous frame
        check_density(ones, prev_offset);
        prev_offset = new_offset;
        step_cycle();
    endtask

    initial begin
        int rnd;
        int wait_cycles;
        int press_len;
        logic [SAMPLE_W-1:0]   word;
        logic [VOL_W-1:0]      v;
        logic [NUM_STAGES-1:0] m;
        rst_n         = 1'b0;
        adc_serial_in = 1'b0;
        pbs           = '0;
        vol           = '1;
        seed          = 60676;
        model_en      = '0;
        for (int k = 0; k < NUM_STAGES; k++) begin
            model_state[k] = 0;
        end
        // DAC level is zero out of reset
        prev_offset = HALF_SCALE;

        repeat (2) @(posedge clk);
        #DRIVE_DELAY;
        check_value("dac_out in reset", int'(dac_out), 0);
        check_value("ws_adc in reset", int'(ws_adc), 0);
        check_value("i2sclk in reset", int'(i2sclk), 0);
        rst_n = 1'b1;

        // Frame timing starts one cycle after reset release
        wait_cycles = 0;
        step_cycle();
        wait_cycles++;
        while (ws_adc !== 1'b1) begin
            step_cycle();
            wait_cycles++;
        end
        check_value("cycles to first word select", wait_cycles, 1);

        for (int row = 0; row < NUM_ROWS; row++) begin
            for (int fr = 0; fr < ROW_FRAMES[row]; fr++) begin
                word      = ROW_SAMPLE[row];
                v         = ROW_VOL[row];
                m         = (fr == 0) ? ROW_MASK[row] : '0;
                press_len = (ROW_MODE[row] == MODE_SHORT) ? SHORT_PRESS : LONG_PRESS;
                // Random rows draw sample, volume and buttons every frame
                if (ROW_MODE[row] == MODE_RAND) begin
                    rnd  = $random(seed);
                    word = rnd[SAMPLE_W-1:0];
                    rnd  = $random(seed);
                    v    = rnd[VOL_W-1:0];
                    m    = rnd[VOL_W +: NUM_STAGES];
                end
                run_frame(word, v, m, press_len);
            end
        end
        // One more frame to measure the last table frame
        run_frame('0, '1, '0, LONG_PRESS);

        $display("Regression passed");
        $finish;
    end

endmodule

// File: audio_effects_top.sv
/*
 * Audio path top level. Serial ADC receiver, four switchable low-pass
 * stages selected by pushbuttons, and a volume-scaled delta-sigma DAC.
 */
`timescale 1ns/1ps

module audio_effects_top
    import audio_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  adc_serial_in,
    input  logic [NUM_STAGES-1:0] pbs,
    input  logic [VOL_W-1:0]      vol,
    output logic                  ws_adc,
    output logic                  i2sclk,
    output logic                  dac_out
);

    // Index 0 is the receiver output, the last index feeds the DAC
    logic signed [SAMPLE_W-1:0] stage_sample [NUM_STAGES+1];
    logic [NUM_STAGES:0]        stage_valid;
    logic [NUM_STAGES-1:0]      stage_en;

    adc_serial_rx rx0 (
        .clk           (clk),
        .rst_n         (rst_n),
        .adc_serial_in (adc_serial_in),
        .ws_adc        (ws_adc),
        .i2sclk        (i2sclk),
        .rx_sample     (stage_sample[0]),
        .rx_valid      (stage_valid[0])
    );

    // All stages bypassed out of reset
    pushbutton_toggle pb0 (
        .clk      (clk),
        .rst_n    (rst_n),
        .pbs      (pbs),
        .stage_en (stage_en)
    );

    // One cycle per stage, bypassed or not
    for (genvar k = 0; k < NUM_STAGES; k++) begin : g_stage
        lowpass_stage lpf (
            .clk        (clk),
            .rst_n      (rst_n),
            .en         (stage_en[k]),
            .in_sample  (stage_sample[k]),
            .in_valid   (stage_valid[k]),
            .out_sample (stage_sample[k+1]),
            .out_valid  (stage_valid[k+1])
        );
    end

    dac_sigma_delta dac0 (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_sample (stage_sample[NUM_STAGES]),
        .in_valid  (stage_valid[NUM_STAGES]),
        .vol       (vol),
        .dac_out   (dac_out)
    );

endmodule

// File: dac_sigma_delta.sv
/*
 * Output DAC. Latches each filtered sample scaled by the volume input and
 * turns it into a first-order delta-sigma bitstream whose ones density
 * follows the offset-binary level.
 */
`timescale 1ns/1ps

module dac_sigma_delta
    import audio_pkg::*;
(
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic signed [SAMPLE_W-1:0] in_sample,
    input  logic                       in_valid,
    input  logic [VOL_W-1:0]           vol,
    output logic                       dac_out
);

    logic [VOL_W-1:0]           shamt;
    logic signed [SAMPLE_W-1:0] level;
    logic [SAMPLE_W-1:0]        offset;
    logic [SAMPLE_W-1:0]        acc;
    logic [SAMPLE_W:0]          sum;

    // Max volume code is no shift, vol 0 divides by eight
    assign shamt = {VOL_W{1'b1}} - vol;

    // Adding half scale is the same as flipping the sign bit
    assign offset = {~level[SAMPLE_W-1], level[SAMPLE_W-2:0]};

    // Carry out of the accumulator is the modulator bit
    assign sum = {1'b0, acc} + {1'b0, offset};

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            level   <= '0;
            acc     <= '0;
            dac_out <= 1'b0;
        end else begin
            // Volume sampled together with the data
            if (in_valid) begin
                level <= in_sample >>> shamt;
            end
            acc     <= sum[SAMPLE_W-1:0];
            dac_out <= sum[SAMPLE_W];
        end
    end

endmodule

// File: pushbutton_toggle.sv
/*
 * Pushbutton front end. Each button is synchronized, debounced on both
 * press and release, and every accepted press flips its stage enable.
 */
`timescale 1ns/1ps

module pushbutton_toggle
    import audio_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic [NUM_STAGES-1:0] pbs,
    output logic [NUM_STAGES-1:0] stage_en
);

    logic [NUM_STAGES-1:0] sync_q1;
    logic [NUM_STAGES-1:0] sync_q2;
    logic [NUM_STAGES-1:0] level;
    logic [NUM_STAGES-1:0] accept;
    logic [DEB_CNT_W-1:0]  deb_cnt [NUM_STAGES];

    // New level held for DEBOUNCE_CYCLES in a row
    always_comb begin
        for (int i = 0; i < NUM_STAGES; i++) begin
            accept[i] = (sync_q2[i] != level[i]) &&
                        (deb_cnt[i] == DEB_CNT_W'(DEBOUNCE_CYCLES - 1));
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            sync_q1  <= '0;
            sync_q2  <= '0;
            level    <= '0;
            stage_en <= '0;
            for (int i = 0; i < NUM_STAGES; i++) begin
                deb_cnt[i] <= '0;
            end
        end else begin
            // Two-flop synchronizer
            sync_q1  <= pbs;
            sync_q2  <= sync_q1;
            // Flip only on an accepted press, release just updates level
            stage_en <= stage_en ^ (accept & sync_q2);
            for (int i = 0; i < NUM_STAGES; i++) begin
                if (sync_q2[i] == level[i]) begin
                    // Glitch or no change, restart the count
                    deb_cnt[i] <= '0;
                end else if (accept[i]) begin
                    deb_cnt[i] <= '0;
                    level[i]   <= sync_q2[i];
                end else begin
                    deb_cnt[i] <= deb_cnt[i] + 1'b1;
                end
            end
        end
    end

endmodule

// File: lowpass_stage.sv
/*
 * One single-pole low-pass stage. Each valid sample moves the state a
 * quarter of the way toward the input. When bypassed the input is passed
 * through registered and the state follows it.
 */
`timescale 1ns/1ps

module lowpass_stage
    import audio_pkg::*;
(
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       en,
    input  logic signed [SAMPLE_W-1:0] in_sample,
    input  logic                       in_valid,
    output logic signed [SAMPLE_W-1:0] out_sample,
    output logic                       out_valid
);

    logic signed [SAMPLE_W-1:0] state;
    logic signed [SAMPLE_W:0]   diff;
    logic signed [SAMPLE_W-1:0] step;
    logic signed [SAMPLE_W-1:0] state_next;

    // One extra bit so full-scale swings cannot wrap
    assign diff = {in_sample[SAMPLE_W-1], in_sample} - {state[SAMPLE_W-1], state};
    // A quarter of the difference fits back in SAMPLE_W
    assign step = SAMPLE_W'(diff >>> LPF_SHIFT);
    // Result lies between state and input so it fits in SAMPLE_W
    assign state_next = state + step;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state     <= '0;
            out_valid <= 1'b0;
        end else begin
            out_valid <= in_valid;
            // Bypassed stage tracks input so re-enable starts from here
            if (in_valid) begin
                state <= en ? state_next : in_sample;
            end
        end
    end

    // State register is the output in both modes
    assign out_sample = state;

endmodule

// File: adc_serial_rx.sv
/*
 * Serial ADC receiver. Generates the bit clock and word select for the
 * converter and shifts in one MSB-first sample per 24-bit frame, then
 * presents it with a one-cycle valid strobe.
 */
`timescale 1ns/1ps

module adc_serial_rx
    import audio_pkg::*;
(
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       adc_serial_in,
    output logic                       ws_adc,
    output logic                       i2sclk,
    output logic signed [SAMPLE_W-1:0] rx_sample,
    output logic                       rx_valid
);

    logic [PHASE_W-1:0]   phase_cnt;
    logic [BIT_CNT_W-1:0] bit_cnt;
    // Only the first 15 bits of the word are buffered
    logic [SAMPLE_W-2:0]  shift_reg;
    logic                 bit_start;
    logic                 data_bit;
    logic                 last_bit;

    // Counter edge where the registered bit clock goes high
    assign bit_start = (phase_cnt == '0);
    // Periods 1 to 16 carry data and the rest of the frame is idle
    assign data_bit  = (bit_cnt >= BIT_CNT_W'(1)) && (bit_cnt <= BIT_CNT_W'(SAMPLE_W));
    // LSB capture completes the word
    assign last_bit  = bit_start && (bit_cnt == BIT_CNT_W'(SAMPLE_W));

    // Free-running phase and bit-period counters
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            phase_cnt <= '0;
            bit_cnt   <= '0;
        end else if (phase_cnt == PHASE_W'(BIT_CYCLES - 1)) begin
            phase_cnt <= '0;
            if (bit_cnt == BIT_CNT_W'(FRAME_BITS - 1)) begin
                bit_cnt <= '0;
            end else begin
                bit_cnt <= bit_cnt + 1'b1;
            end
        end else begin
            phase_cnt <= phase_cnt + 1'b1;
        end
    end

    // Registered outputs trail the counters by one cycle
    // and stay low for the first cycle out of reset
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            i2sclk   <= 1'b0;
            ws_adc   <= 1'b0;
            rx_valid <= 1'b0;
        end else begin
            i2sclk   <= (phase_cnt < PHASE_W'(BIT_CYCLES / 2));
            ws_adc   <= (bit_cnt == '0);
            rx_valid <= last_bit;
        end
    end

    // Data sampled on the same edge that raises i2sclk
    always_ff @(posedge clk) begin
        if (bit_start && data_bit) begin
            shift_reg <= {shift_reg[SAMPLE_W-3:0], adc_serial_in};
        end
        // Held word takes the LSB directly and stays put
        // while the next frame shifts in
        if (last_bit) begin
            rx_sample <= $signed({shift_reg, adc_serial_in});
        end
    end

endmodule

// File: audio_pkg.sv
/*
 * Shared constants for the audio path: sample format, ADC frame timing,
 * filter cascade size and button debounce. Imported by every RTL module
 * and by the testbench.
 */

package audio_pkg;

    // Signed two's complement audio word
    localparam int SAMPLE_W = 16;

    // ADC serial frame, bit clock high for the first half of each bit period
    localparam int BIT_CYCLES = 4;
    localparam int FRAME_BITS = 24;
    localparam int PHASE_W    = $clog2(BIT_CYCLES);
    localparam int BIT_CNT_W  = $clog2(FRAME_BITS);

    // Filter cascade, one pushbutton per stage
    localparam int NUM_STAGES = 4;
    // Coefficient 1/4 as a right shift
    localparam int LPF_SHIFT  = 2;

    // Stable cycles before a button level is accepted
    localparam int DEBOUNCE_CYCLES = 8;
    localparam int DEB_CNT_W       = $clog2(DEBOUNCE_CYCLES);

    // Volume input, shift is max code minus vol
    localparam int VOL_W = 2;

endpackage
